// ==== logic/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

    // tlb geometry
    localparam int TLB_ENTRY_NUM = 16;
    localparam int TLB_IDX_W     = $clog2(TLB_ENTRY_NUM);

    typedef logic [31:0]          vaddr_t;
    typedef logic [31:0]          paddr_t;
    typedef logic [9:0]           asid_t;
    typedef logic [18:0]          vppn_t;   // one vppn covers an even/odd pair
    typedef logic [19:0]          ppn_t;
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;
    typedef logic [5:0]           ecode_t;

    // loongarch exception codes
    localparam ecode_t ECODE_NONE = 6'h00;
    localparam ecode_t ECODE_PIL  = 6'h01;
    localparam ecode_t ECODE_PIS  = 6'h02;
    localparam ecode_t ECODE_PIF  = 6'h03;
    localparam ecode_t ECODE_PME  = 6'h04;
    localparam ecode_t ECODE_PPI  = 6'h07;
    localparam ecode_t ECODE_TLBR = 6'h3f;

    typedef enum logic [1:0] {
        MEM_FETCH = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_type_e;

    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_SRCH    = 3'd1,
        OP_RD      = 3'd2,
        OP_WR      = 3'd3,
        OP_FILL    = 3'd4,
        OP_INV_ALL = 3'd5
    } tlb_op_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,
        ST_SWEEP  = 2'd2,
        ST_DONE   = 2'd3
    } maint_state_e;

    typedef struct packed {
        logic  e;
        logic  g;
        logic  huge_page;   // 4 MB pair, 2 MB per half
        asid_t asid;
        vppn_t vppn;
    } tlb_key_t;

    typedef struct packed {
        logic       v;
        logic       d;
        logic [1:0] mat;
        logic [1:0] plv;
        ppn_t       ppn;
    } tlb_value_t;

    typedef struct packed {
        tlb_key_t         key;
        tlb_value_t [1:0] value;   // [0] even half, [1] odd half
    } tlb_entry_t;

    typedef struct packed {
        logic [1:0] plv;
        logic       da;
        logic       pg;
        logic [1:0] datf;
        logic [1:0] datm;
    } crmd_t;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        crmd_t crmd;
        asid_t asid;
        dmw_t  dmw0;
        dmw_t  dmw1;
    } csr_view_t;

    typedef struct packed {
        paddr_t     pa;
        logic [1:0] mat;
        logic       valid;
    } trans_result_t;

    typedef struct packed {
        logic       found;
        tlb_idx_t   index;
        tlb_value_t value;       // half already picked by the va
        logic       huge_page;
    } tlb_hit_t;

endpackage

`default_nettype wire

// ==== logic/tlb_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_array (
    input  logic                clk,
    input  logic                arst_n_i,
    input  mmu_pkg::vaddr_t     va_i,
    input  mmu_pkg::asid_t      asid_i,
    input  logic                wr_en_i,
    input  mmu_pkg::tlb_idx_t   wr_idx_i,
    input  mmu_pkg::tlb_entry_t wr_entry_i,
    input  logic                clear_en_i,
    input  mmu_pkg::tlb_idx_t   clear_idx_i,
    input  mmu_pkg::tlb_idx_t   rd_idx_i,
    output mmu_pkg::tlb_hit_t   hit_o,
    output mmu_pkg::tlb_entry_t rd_entry_o
);
    import mmu_pkg::*;

    logic [TLB_ENTRY_NUM-1:0] e_q;        // valid bits, the only state under reset
    tlb_key_t                 key_q [TLB_ENTRY_NUM];
    tlb_value_t [1:0]         val_q [TLB_ENTRY_NUM];
    logic [TLB_ENTRY_NUM-1:0] wr_sel;
    logic [TLB_ENTRY_NUM-1:0] match_vec;

    // huge pages compare only the upper 10 bits of the vppn
    function automatic logic vppn_match(input vaddr_t va, input tlb_key_t key);
        if (key.huge_page) begin
            return va[31:22] == key.vppn[18:9];
        end
        return va[31:13] == key.vppn;
    endfunction

    assign wr_sel = wr_en_i ? (TLB_ENTRY_NUM'(1) << wr_idx_i) : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
                if (clear_en_i && (clear_idx_i == tlb_idx_t'(i))) begin
                    e_q[i] <= 1'b0;               // invalidate sweep wins
                end else if (wr_sel[i]) begin
                    e_q[i] <= wr_entry_i.key.e;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            if (wr_sel[i]) begin
                key_q[i] <= wr_entry_i.key;
                val_q[i] <= wr_entry_i.value;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            match_vec[i] = e_q[i]
                        && (key_q[i].g || (key_q[i].asid == asid_i))
                        && vppn_match(va_i, key_q[i]);
        end
    end

    // walk downwards so the lowest matching index is kept
    always_comb begin
        hit_o = '0;
        for (int i = TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                hit_o.found     = 1'b1;
                hit_o.index     = tlb_idx_t'(i);
                hit_o.huge_page = key_q[i].huge_page;
                hit_o.value     = val_q[i][key_q[i].huge_page ? va_i[21] : va_i[12]];
            end
        end
    end

    always_comb begin
        rd_entry_o       = '0;
        rd_entry_o.key   = key_q[rd_idx_i];
        rd_entry_o.key.e = e_q[rd_idx_i];   // live valid bit, sweep may have cleared it
        rd_entry_o.value = val_q[rd_idx_i];
    end

    // software must never install overlapping pages
    a_single_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(match_vec))
        else $error("tlb_array: more than one entry matches va %h", va_i);

endmodule

`default_nettype wire

// ==== logic/addr_xlate.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_xlate (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   flush_i,
    input  mmu_pkg::vaddr_t        va_i,
    input  mmu_pkg::mem_type_e     mem_type_i,
    input  mmu_pkg::csr_view_t     csr_i,
    input  mmu_pkg::tlb_hit_t      hit_i,
    output mmu_pkg::trans_result_t result_o,
    output mmu_pkg::ecode_t        ecode_o
);
    import mmu_pkg::*;

    logic          dmw0_hit;
    logic          dmw1_hit;
    paddr_t        tlb_pa;
    trans_result_t res_d;
    ecode_t        ecode_d;

    // window must match the segment and allow the current plv
    function automatic logic dmw_match(input dmw_t w, input logic [1:0] plv, input vaddr_t va);
        logic plv_ok;
        plv_ok = ((plv == 2'd0) && w.plv0) || ((plv == 2'd3) && w.plv3);
        return plv_ok && (w.vseg == va[31:29]);
    endfunction

    assign dmw0_hit = dmw_match(csr_i.dmw0, csr_i.crmd.plv, va_i);
    assign dmw1_hit = dmw_match(csr_i.dmw1, csr_i.crmd.plv, va_i);

    assign tlb_pa = hit_i.huge_page ? {hit_i.value.ppn[19:9], va_i[20:0]}
                                    : {hit_i.value.ppn, va_i[11:0]};

    always_comb begin
        res_d   = '0;
        ecode_d = ECODE_NONE;
        if (csr_i.crmd.da) begin
            res_d.pa    = va_i;
            res_d.mat   = (mem_type_i == MEM_FETCH) ? csr_i.crmd.datf : csr_i.crmd.datm;
            res_d.valid = 1'b1;
        end else if (dmw0_hit) begin
            res_d.pa    = {csr_i.dmw0.pseg, va_i[28:0]};
            res_d.mat   = csr_i.dmw0.mat;
            res_d.valid = 1'b1;
        end else if (dmw1_hit) begin
            res_d.pa    = {csr_i.dmw1.pseg, va_i[28:0]};
            res_d.mat   = csr_i.dmw1.mat;
            res_d.valid = 1'b1;
        end else if (!hit_i.found) begin
            ecode_d = ECODE_TLBR;
        end else if (!hit_i.value.v) begin
            case (mem_type_i)
                MEM_FETCH: ecode_d = ECODE_PIF;
                MEM_STORE: ecode_d = ECODE_PIS;
                default:   ecode_d = ECODE_PIL;
            endcase
        end else if (csr_i.crmd.plv > hit_i.value.plv) begin
            ecode_d = ECODE_PPI;                  // plv 3 cannot touch a plv 0 page
        end else if ((mem_type_i == MEM_STORE) && !hit_i.value.d) begin
            ecode_d = ECODE_PME;                  // first store to a clean page
        end else begin
            res_d.pa    = tlb_pa;
            res_d.mat   = hit_i.value.mat;
            res_d.valid = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
            ecode_o  <= ECODE_NONE;
        end else if (flush_i) begin
            result_o <= '0;
            ecode_o  <= ECODE_NONE;
        end else begin
            result_o <= res_d;
            ecode_o  <= ecode_d;
        end
    end

    a_valid_no_ecode: assert property (@(posedge clk) disable iff (!arst_n_i)
        result_o.valid |-> (ecode_o == ECODE_NONE))
        else $error("addr_xlate: valid result with ecode %h", ecode_o);

endmodule

`default_nettype wire

// ==== logic/tlb_maint_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_maint_fsm (
    input  logic                clk,
    input  logic                arst_n_i,
    input  mmu_pkg::tlb_op_e    op_i,
    input  mmu_pkg::tlb_idx_t   idx_i,
    input  mmu_pkg::tlb_entry_t entry_i,
    input  mmu_pkg::tlb_hit_t   hit_i,
    input  mmu_pkg::tlb_entry_t rd_entry_i,
    input  mmu_pkg::tlb_idx_t   fill_idx_i,
    input  mmu_pkg::tlb_idx_t   sweep_idx_i,
    input  logic                sweep_last_i,
    output logic                wr_en_o,
    output mmu_pkg::tlb_idx_t   wr_idx_o,
    output mmu_pkg::tlb_entry_t wr_entry_o,
    output logic                clear_en_o,
    output mmu_pkg::tlb_idx_t   clear_idx_o,
    output mmu_pkg::tlb_idx_t   rd_idx_o,
    output logic                sweep_step_o,
    output logic                fill_step_o,
    output logic                busy_o,
    output logic                done_o,
    output logic                srch_found_o,
    output mmu_pkg::tlb_idx_t   srch_idx_o,
    output mmu_pkg::tlb_entry_t rd_entry_o
);
    import mmu_pkg::*;

    maint_state_e state_q;
    maint_state_e state_d;
    tlb_op_e      op_q;
    tlb_idx_t     idx_q;
    tlb_entry_t   entry_q;
    logic         op_start;
    logic         is_write;

    assign op_start = (state_q == ST_IDLE)
                   && (op_i inside {OP_SRCH, OP_RD, OP_WR, OP_FILL, OP_INV_ALL});
    assign is_write = (op_q == OP_WR) || (op_q == OP_FILL);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (op_start) state_d = ST_ACCESS;
            ST_ACCESS: state_d = (op_q == OP_INV_ALL) ? ST_SWEEP : ST_DONE;
            ST_SWEEP:  if (sweep_last_i) state_d = ST_DONE;
            default:   state_d = ST_IDLE;     // done lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= ST_IDLE;
            op_q         <= OP_NONE;
            srch_found_o <= 1'b0;
        end else begin
            state_q <= state_d;
            if (op_start) begin
                op_q <= op_i;
                if (op_i == OP_SRCH) srch_found_o <= hit_i.found;   // key is va_i at strobe
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_start) begin
            idx_q   <= idx_i;
            entry_q <= entry_i;
            if (op_i == OP_SRCH) srch_idx_o <= hit_i.index;
        end
        if ((state_q == ST_ACCESS) && (op_q == OP_RD)) begin
            rd_entry_o <= rd_entry_i;
        end
    end

    // writes land on the edge into ST_DONE
    assign wr_en_o      = (state_q == ST_ACCESS) && is_write;
    assign wr_idx_o     = (op_q == OP_FILL) ? fill_idx_i : idx_q;
    assign wr_entry_o   = entry_q;
    assign fill_step_o  = (state_q == ST_ACCESS) && (op_q == OP_FILL);
    assign rd_idx_o     = idx_q;

    assign clear_en_o   = (state_q == ST_SWEEP);
    assign clear_idx_o  = sweep_idx_i;
    assign sweep_step_o = (state_q == ST_SWEEP);

    assign busy_o = (state_q != ST_IDLE);
    assign done_o = (state_q == ST_DONE);

    a_no_op_while_busy: assert property (@(posedge clk) disable iff (!arst_n_i)
        busy_o |-> (op_i == OP_NONE))
        else $error("tlb_maint_fsm: op %0d issued while busy", op_i);

endmodule

`default_nettype wire

// ==== logic/tlb_index_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_index_counter (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              sweep_step_i,
    input  logic              fill_step_i,
    output mmu_pkg::tlb_idx_t sweep_idx_o,
    output logic              sweep_last_o,
    output mmu_pkg::tlb_idx_t fill_idx_o
);
    import mmu_pkg::*;

    localparam tlb_idx_t LAST_IDX = tlb_idx_t'(TLB_ENTRY_NUM - 1);

    assign sweep_last_o = (sweep_idx_o == LAST_IDX);

    // a full sweep always ends back at 0, ready for the next one
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sweep_idx_o <= '0;
        end else if (sweep_step_i) begin
            sweep_idx_o <= sweep_last_o ? '0 : sweep_idx_o + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fill_idx_o <= '0;
        end else if (fill_step_i) begin
            fill_idx_o <= (fill_idx_o == LAST_IDX) ? '0 : fill_idx_o + 1'b1;   // round robin
        end
    end

endmodule

`default_nettype wire

// ==== logic/mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   flush_i,
    input  mmu_pkg::vaddr_t        va_i,
    input  mmu_pkg::mem_type_e     mem_type_i,
    input  mmu_pkg::csr_view_t     csr_i,
    input  mmu_pkg::tlb_op_e       op_i,
    input  mmu_pkg::tlb_idx_t      idx_i,
    input  mmu_pkg::tlb_entry_t    entry_i,
    output mmu_pkg::trans_result_t result_o,
    output mmu_pkg::ecode_t        ecode_o,
    output logic                   busy_o,
    output logic                   done_o,
    output logic                   srch_found_o,
    output mmu_pkg::tlb_idx_t      srch_idx_o,
    output mmu_pkg::tlb_entry_t    rd_entry_o
);
    import mmu_pkg::*;

    tlb_hit_t   hit;          // shared by lookup and search
    tlb_entry_t arr_rd_entry;
    logic       wr_en;
    tlb_idx_t   wr_idx;
    tlb_entry_t wr_entry;
    logic       clear_en;
    tlb_idx_t   clear_idx;
    tlb_idx_t   rd_idx;
    logic       sweep_step;
    logic       fill_step;
    tlb_idx_t   sweep_idx;
    logic       sweep_last;
    tlb_idx_t   fill_idx;

    tlb_array u_tlb_array (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .va_i        (va_i),
        .asid_i      (csr_i.asid),
        .wr_en_i     (wr_en),
        .wr_idx_i    (wr_idx),
        .wr_entry_i  (wr_entry),
        .clear_en_i  (clear_en),
        .clear_idx_i (clear_idx),
        .rd_idx_i    (rd_idx),
        .hit_o       (hit),
        .rd_entry_o  (arr_rd_entry)
    );

    addr_xlate u_addr_xlate (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .flush_i    (flush_i),
        .va_i       (va_i),
        .mem_type_i (mem_type_i),
        .csr_i      (csr_i),
        .hit_i      (hit),
        .result_o   (result_o),
        .ecode_o    (ecode_o)
    );

    tlb_maint_fsm u_tlb_maint_fsm (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .op_i         (op_i),
        .idx_i        (idx_i),
        .entry_i      (entry_i),
        .hit_i        (hit),
        .rd_entry_i   (arr_rd_entry),
        .fill_idx_i   (fill_idx),
        .sweep_idx_i  (sweep_idx),
        .sweep_last_i (sweep_last),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx),
        .wr_entry_o   (wr_entry),
        .clear_en_o   (clear_en),
        .clear_idx_o  (clear_idx),
        .rd_idx_o     (rd_idx),
        .sweep_step_o (sweep_step),
        .fill_step_o  (fill_step),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .srch_found_o (srch_found_o),
        .srch_idx_o   (srch_idx_o),
        .rd_entry_o   (rd_entry_o)
    );

    tlb_index_counter u_tlb_index_counter (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .sweep_step_i (sweep_step),
        .fill_step_i  (fill_step),
        .sweep_idx_o  (sweep_idx),
        .sweep_last_o (sweep_last),
        .fill_idx_o   (fill_idx)
    );

endmodule

`default_nettype wire

// ==== test/mmu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;
    import mmu_pkg::*;

    localparam int OP_TIMEOUT = 100;   // cycles

    typedef struct packed {
        vaddr_t      va;
        mem_type_e   mem;
        csr_view_t   csr;
        logic [31:0] off_mask;   // offset bits that pass through to the pa
        paddr_t      pa;
        logic [1:0]  mat;
        logic        valid;
        ecode_t      ecode;
    } row_t;

    logic          clk;
    logic          arst_n_i;
    logic          flush_i;
    vaddr_t        va_i;
    mem_type_e     mem_type_i;
    csr_view_t     csr_i;
    tlb_op_e       op_i;
    tlb_idx_t      idx_i;
    tlb_entry_t    entry_i;
    trans_result_t result_o;
    ecode_t        ecode_o;
    logic          busy_o;
    logic          done_o;
    logic          srch_found_o;
    tlb_idx_t      srch_idx_o;
    tlb_entry_t    rd_entry_o;

    int         seed;
    row_t       rows[$];
    string      row_names[$];
    csr_view_t  csr_da;
    csr_view_t  csr_k0;   // paged, plv 0, asid 5
    csr_view_t  csr_k3;   // paged, plv 3, asid 5
    csr_view_t  csr_o0;   // paged, plv 0, other asid
    tlb_entry_t ent_4k;
    tlb_entry_t ent_huge;
    tlb_entry_t ent_exc;
    tlb_entry_t ent_fill;

    mmu dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .va_i         (va_i),
        .mem_type_i   (mem_type_i),
        .csr_i        (csr_i),
        .op_i         (op_i),
        .idx_i        (idx_i),
        .entry_i      (entry_i),
        .result_o     (result_o),
        .ecode_o      (ecode_o),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .srch_found_o (srch_found_o),
        .srch_idx_o   (srch_idx_o),
        .rd_entry_o   (rd_entry_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input string what,
                             input logic [95:0] exp_v, input logic [95:0] act_v);
        assert (act_v === exp_v) else begin
            $display("CHECK FAILED %s (%s): expected %0h, actual %0h",
                     name, what, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            $display("ERROR: %s", msg);
            abort_run();
        end
    endtask

    // dmw0 maps 0x8xxxxxxx to 0x2xxxxxxx for plv 0 only, dmw1 maps 0xa... to 0x0... for both
    function automatic csr_view_t make_csr(input logic [1:0] plv, input logic da,
                                           input asid_t asid);
        csr_view_t c;
        c           = '0;
        c.crmd.plv  = plv;
        c.crmd.da   = da;
        c.crmd.pg   = !da;
        c.crmd.datf = 2'd1;
        c.crmd.datm = 2'd2;
        c.asid      = asid;
        c.dmw0.plv0 = 1'b1;
        c.dmw0.mat  = 2'd1;
        c.dmw0.pseg = 3'h1;
        c.dmw0.vseg = 3'h4;
        c.dmw1.plv0 = 1'b1;
        c.dmw1.plv3 = 1'b1;
        c.dmw1.pseg = 3'h0;
        c.dmw1.vseg = 3'h5;
        return c;
    endfunction

    function automatic tlb_value_t make_val(input logic v, input logic d, input logic [1:0] mat,
                                            input logic [1:0] plv, input ppn_t ppn);
        tlb_value_t t;
        t.v   = v;
        t.d   = d;
        t.mat = mat;
        t.plv = plv;
        t.ppn = ppn;
        return t;
    endfunction

    function automatic tlb_entry_t make_entry(input logic g, input logic huge, input asid_t asid,
                                              input vppn_t vppn, input tlb_value_t even,
                                              input tlb_value_t odd);
        tlb_entry_t t;
        t.key.e         = 1'b1;
        t.key.g         = g;
        t.key.huge_page = huge;
        t.key.asid      = asid;
        t.key.vppn      = vppn;
        t.value[0]      = even;
        t.value[1]      = odd;
        return t;
    endfunction

    task automatic add_row(input string name, input vaddr_t va, input mem_type_e mem,
                           input csr_view_t csr, input logic [31:0] off_mask, input paddr_t pa,
                           input logic [1:0] mat, input logic valid, input ecode_t ecode);
        row_t r;
        r.va       = va;
        r.mem      = mem;
        r.csr      = csr;
        r.off_mask = off_mask;
        r.pa       = pa;
        r.mat      = mat;
        r.valid    = valid;
        r.ecode    = ecode;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    // one lookup per row, result checked one cycle later
    task automatic apply_rows();
        row_t   r;
        vaddr_t off;
        paddr_t exp_pa;
        for (int i = 0; i < rows.size(); i++) begin
            r          = rows[i];
            off        = vaddr_t'($random(seed)) & r.off_mask;
            exp_pa     = r.valid ? (r.pa | off) : '0;
            va_i       = r.va | off;
            mem_type_i = r.mem;
            csr_i      = r.csr;
            @(negedge clk);
            check_val(row_names[i], "pa", exp_pa, result_o.pa);
            check_val(row_names[i], "mat", r.mat, result_o.mat);
            check_val(row_names[i], "valid", r.valid, result_o.valid);
            check_val(row_names[i], "ecode", r.ecode, ecode_o);
        end
        rows.delete();
        row_names.delete();
    endtask

    task automatic run_op(input string name, input tlb_op_e op, input tlb_idx_t idx,
                          input tlb_entry_t ent, input vaddr_t key_va, input int exp_cycles);
        int cycles;
        op_i    = op;
        idx_i   = idx;
        entry_i = ent;
        va_i    = key_va;   // search key
        cycles  = 0;
        do begin
            @(negedge clk);
            op_i = OP_NONE;
            cycles++;
            check_true(busy_o, $sformatf("%s: busy_o low while the operation runs", name));
        end while (!done_o && (cycles < OP_TIMEOUT));
        check_true(done_o, $sformatf("%s: timeout, done_o never pulsed", name));
        check_val(name, "done latency", exp_cycles, cycles);
        @(negedge clk);
        check_val(name, "busy after done", 1'b0, busy_o);
        check_val(name, "done pulse width", 1'b0, done_o);
    endtask

    initial begin
        seed       = 32'h804c34e2;
        arst_n_i   = 1'b0;
        flush_i    = 1'b0;
        va_i       = '0;
        mem_type_i = MEM_LOAD;
        csr_i      = '0;
        op_i       = OP_NONE;
        idx_i      = '0;
        entry_i    = '0;
        csr_da     = make_csr(2'd0, 1'b1, 10'd5);
        csr_k0     = make_csr(2'd0, 1'b0, 10'd5);
        csr_k3     = make_csr(2'd3, 1'b0, 10'd5);
        csr_o0     = make_csr(2'd0, 1'b0, 10'd6);

        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        check_val("reset", "valid", 1'b0, result_o.valid);
        check_val("reset", "busy", 1'b0, busy_o);
        check_val("reset", "done", 1'b0, done_o);

        // direct address and windows, tlb still empty
        add_row("da_fetch", 32'h1234_5000, MEM_FETCH, csr_da, 32'h0000_0fff,
                32'h1234_5000, 2'd1, 1'b1, ECODE_NONE);
        add_row("da_load", 32'ha000_0000, MEM_LOAD, csr_da, 32'h0fff_ffff,
                32'ha000_0000, 2'd2, 1'b1, ECODE_NONE);
        add_row("dmw0_load", 32'h8000_0000, MEM_LOAD, csr_k0, 32'h1fff_ffff,
                32'h2000_0000, 2'd1, 1'b1, ECODE_NONE);
        add_row("dmw0_plv3_tlbr", 32'h8000_0000, MEM_LOAD, csr_k3, 32'h1fff_ffff,
                '0, 2'd0, 1'b0, ECODE_TLBR);
        add_row("dmw1_plv3_fetch", 32'ha000_0000, MEM_FETCH, csr_k3, 32'h1fff_ffff,
                32'h0000_0000, 2'd0, 1'b1, ECODE_NONE);
        apply_rows();

        va_i       = 32'h1234_5678;
        mem_type_i = MEM_LOAD;
        csr_i      = csr_da;
        flush_i    = 1'b1;
        @(negedge clk);
        check_val("flush_da", "result", '0, result_o);
        csr_i = csr_k0;                          // tlb still empty, a refill otherwise
        @(negedge clk);
        check_val("flush_tlbr", "ecode", ECODE_NONE, ecode_o);
        flush_i = 1'b0;

        ent_4k   = make_entry(1'b0, 1'b0, 10'd5, 19'h00008,
                              make_val(1'b1, 1'b1, 2'd1, 2'd3, 20'h12345),
                              make_val(1'b1, 1'b1, 2'd2, 2'd3, 20'h54321));
        ent_huge = make_entry(1'b1, 1'b1, 10'h3ff, 19'h00200,
                              make_val(1'b1, 1'b1, 2'd1, 2'd3, 20'h02000),
                              make_val(1'b1, 1'b1, 2'd1, 2'd3, 20'h02200));
        ent_exc  = make_entry(1'b1, 1'b0, 10'd0, 19'h00010,
                              make_val(1'b0, 1'b0, 2'd0, 2'd0, 20'h00000),
                              make_val(1'b1, 1'b0, 2'd1, 2'd0, 20'h00777));
        ent_fill = make_entry(1'b1, 1'b0, 10'd0, 19'h00018,
                              make_val(1'b1, 1'b1, 2'd0, 2'd3, 20'habcde),
                              make_val(1'b0, 1'b0, 2'd0, 2'd0, 20'h00000));

        csr_i = csr_k0;
        run_op("wr_4k", OP_WR, 4'd1, ent_4k, '0, 2);
        run_op("wr_huge", OP_WR, 4'd2, ent_huge, '0, 2);
        run_op("wr_exc", OP_WR, 4'd3, ent_exc, '0, 2);
        run_op("rd_4k", OP_RD, 4'd1, '0, '0, 2);
        check_val("rd_4k", "entry", ent_4k, rd_entry_o);
        csr_i = csr_o0;                          // global entry found under any asid
        run_op("srch_huge", OP_SRCH, '0, '0, 32'h0060_0000, 2);
        check_val("srch_huge", "found", 1'b1, srch_found_o);
        check_val("srch_huge", "index", 4'd2, srch_idx_o);
        run_op("srch_miss", OP_SRCH, '0, '0, 32'h7000_0000, 2);
        check_val("srch_miss", "found", 1'b0, srch_found_o);
        run_op("fill", OP_FILL, 4'd9, ent_fill, '0, 2);

        add_row("tlb4k_even", 32'h0001_0000, MEM_LOAD, csr_k0, 32'h0000_0fff,
                32'h1234_5000, 2'd1, 1'b1, ECODE_NONE);
        add_row("tlb4k_odd_store", 32'h0001_1000, MEM_STORE, csr_k0, 32'h0000_0fff,
                32'h5432_1000, 2'd2, 1'b1, ECODE_NONE);
        add_row("asid_tlbr", 32'h0001_0000, MEM_LOAD, csr_o0, 32'h0000_0fff,
                '0, 2'd0, 1'b0, ECODE_TLBR);
        add_row("huge_even", 32'h0040_0000, MEM_LOAD, csr_k0, 32'h001f_ffff,
                32'h0200_0000, 2'd1, 1'b1, ECODE_NONE);
        add_row("huge_odd_global", 32'h0060_0000, MEM_FETCH, csr_o0, 32'h001f_ffff,
                32'h0220_0000, 2'd1, 1'b1, ECODE_NONE);
        add_row("pif", 32'h0002_0000, MEM_FETCH, csr_k0, 32'h0000_0fff,
                '0, 2'd0, 1'b0, ECODE_PIF);
        add_row("pil", 32'h0002_0000, MEM_LOAD, csr_k0, 32'h0000_0fff,
                '0, 2'd0, 1'b0, ECODE_PIL);
        add_row("pis_plv3", 32'h0002_0000, MEM_STORE, csr_k3, 32'h0000_0fff,
                '0, 2'd0, 1'b0, ECODE_PIS);
        add_row("ppi_store", 32'h0002_1000, MEM_STORE, csr_k3, 32'h0000_0fff,
                '0, 2'd0, 1'b0, ECODE_PPI);
        add_row("pme", 32'h0002_1000, MEM_STORE, csr_k0, 32'h0000_0fff,
                '0, 2'd0, 1'b0, ECODE_PME);
        add_row("exc_odd_load", 32'h0002_1000, MEM_LOAD, csr_k0, 32'h0000_0fff,
                32'h0077_7000, 2'd1, 1'b1, ECODE_NONE);
        add_row("fill_hit", 32'h0003_0000, MEM_LOAD, csr_k0, 32'h0000_0fff,
                32'habcd_e000, 2'd0, 1'b1, ECODE_NONE);
        apply_rows();

        // one entry cleared per cycle
        run_op("inv_all", OP_INV_ALL, '0, '0, '0, TLB_ENTRY_NUM + 2);
        add_row("tlb4k_after_inv", 32'h0001_0000, MEM_LOAD, csr_k0, 32'h0000_0fff,
                '0, 2'd0, 1'b0, ECODE_TLBR);
        add_row("huge_after_inv", 32'h0060_0000, MEM_FETCH, csr_o0, 32'h001f_ffff,
                '0, 2'd0, 1'b0, ECODE_TLBR);
        add_row("exc_after_inv", 32'h0002_1000, MEM_LOAD, csr_k0, 32'h0000_0fff,
                '0, 2'd0, 1'b0, ECODE_TLBR);
        add_row("fill_after_inv", 32'h0003_0000, MEM_LOAD, csr_k0, 32'h0000_0fff,
                '0, 2'd0, 1'b0, ECODE_TLBR);
        apply_rows();
        run_op("rd_after_inv", OP_RD, 4'd1, '0, '0, 2);
        check_val("rd_after_inv", "e bit", 1'b0, rd_entry_o.key.e);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/mmu_pkg.sv
logic/tlb_array.sv
logic/addr_xlate.sv
logic/tlb_maint_fsm.sv
logic/tlb_index_counter.sv
logic/mmu.sv
test/mmu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the mmu testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build/obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module mmu_tb \
        -f src.f \
        -Mdir "$BUILD_DIR" \
        -o mmu_tb; then
    echo "run.sh: verilator build failed"
    exit 1
fi

if ! "./$BUILD_DIR/mmu_tb"; then
    echo "run.sh: simulation failed"
    exit 1
fi

echo "run.sh: simulation finished"
exit 0
